//--- filelist.f
verilog/uart_dma_pkg.sv
verilog/uart_cmd_parser.sv
verilog/uart_wr_buffer.sv
verilog/uart_rd_serializer.sv
verilog/dma_ctrl.sv
verilog/uart_dma_top.sv
verif/tb_dma_mem_model.sv
verif/tb_uart_dma_top.sv

//--- Bender.yml
package:
  name: uart_dma_bridge

sources:
  - verilog/uart_dma_pkg.sv
  - verilog/uart_cmd_parser.sv
  - verilog/uart_wr_buffer.sv
  - verilog/uart_rd_serializer.sv
  - verilog/dma_ctrl.sv
  - verilog/uart_dma_top.sv
  - target: simulation
    files:
      - verif/tb_dma_mem_model.sv
      - verif/tb_uart_dma_top.sv

//--- verif/tb_uart_dma_top.sv
`timescale 1ns/1ps

module tb_uart_dma_top;

	localparam int BURST_LEN    = 16;
	localparam int BUSY_TIMEOUT = 4000;
	localparam int BYTE_TIMEOUT = 400;
	// Frame, payload and transmit bytes of the five tests
	localparam int TEST_BYTES   = 85 + 324 + 51 + 181 + 188;
	localparam int WATCHDOG_NS  = TEST_BYTES * 4 * 100 + 200000;

	localparam logic [7:0] OPEN_BRACE  = 8'h7b;
	localparam logic [7:0] CLOSE_BRACE = 8'h7d;

	logic                    sys_clk;
	logic                    axi_reset_n;
	logic                    rx_valid;
	logic [7:0]              rx_data;
	logic                    tx_busy;
	logic                    tx_start;
	logic [7:0]              tx_data;
	logic                    busy;
	uart_dma_pkg::dma_wr_m_t wr_m;
	uart_dma_pkg::dma_wr_s_t wr_s;
	uart_dma_pkg::dma_rd_m_t rd_m;
	uart_dma_pkg::dma_rd_s_t rd_s;

	logic [31:0] rng_state;
	logic [31:0] busy_rnd;
	logic        busy_rand;
	logic        busy_hold;
	logic [7:0]  pay_q [$];
	logic [7:0]  exp_q [$];
	logic [7:0]  tx_got [$];

	uart_dma_top #(.BURST_LEN(BURST_LEN)) u_dut (
		.i_sys_clk     (sys_clk),
		.i_axi_reset_n (axi_reset_n),
		.i_rx_valid    (rx_valid),
		.i_rx_data     (rx_data),
		.i_tx_busy     (tx_busy),
		.o_tx_start    (tx_start),
		.o_tx_data     (tx_data),
		.o_busy        (busy),
		.o_wr          (wr_m),
		.i_wr          (wr_s),
		.o_rd          (rd_m),
		.i_rd          (rd_s)
	);

	tb_dma_mem_model #(.BURST_LEN(BURST_LEN)) u_mem (
		.i_sys_clk     (sys_clk),
		.i_axi_reset_n (axi_reset_n),
		.i_wr          (wr_m),
		.o_wr          (wr_s),
		.i_rd          (rd_m),
		.o_rd          (rd_s)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("Watchdog expired before the tests finished");
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and compares
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %h got %h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %h got %h", name, expected, actual);
			stop_run();
		end
	endtask

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Transmitter model and byte capture
	always @(posedge sys_clk) begin
		if (busy_rand === 1'b1) begin
			busy_rnd = next_rand();
			tx_busy <= busy_rnd[0];
		end else begin
			tx_busy <= busy_hold;
		end
	end

	always @(posedge sys_clk) begin
		if (tx_start === 1'b1) begin
			if (tx_busy)
				report_failure("o_tx_start pulsed while i_tx_busy was high");
			tx_got.push_back(tx_data);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// UART stimulus
	////////////////////////////////////////////////////////////////////////////

	// Random idle gap after each byte
	task automatic send_byte(input logic [7:0] b);
		logic [31:0] r;
		@(posedge sys_clk);
		rx_valid <= 1'b1;
		rx_data  <= b;
		@(posedge sys_clk);
		rx_valid <= 1'b0;
		r = next_rand();
		repeat (r % 3) @(posedge sys_clk);
	endtask

	task automatic send_frame(input logic [7:0] id, input logic [31:0] arg);
		send_byte(OPEN_BRACE);
		send_byte(id);
		send_byte(arg[31:24]);
		send_byte(arg[23:16]);
		send_byte(arg[15:8]);
		send_byte(arg[7:0]);
		send_byte(CLOSE_BRACE);
	endtask

	task automatic wait_busy(input logic level, input string what);
		int n;
		n = 0;
		while (busy !== level) begin
			@(posedge sys_clk);
			n++;
			if (n > BUSY_TIMEOUT)
				report_failure($sformatf("o_busy did not %s", what));
		end
	endtask

	task automatic start_transfer(input uart_dma_pkg::dma_op_e op);
		send_frame(uart_dma_pkg::CMD_START, {30'd0, op, 1'b1});
		wait_busy(1'b1, "rise after the start frame");
	endtask

	task automatic send_payload(input int n_bytes);
		logic [31:0] r;
		pay_q.delete();
		for (int i = 0; i < n_bytes; i++) begin
			r = next_rand();
			pay_q.push_back(r[7:0]);
			send_byte(r[7:0]);
		end
	endtask

	// Words go out most significant byte first
	task automatic preload_words(input logic [31:0] addr, input int n);
		logic [31:0] r;
		exp_q.delete();
		for (int k = 0; k < n; k++) begin
			r = next_rand();
			u_mem.mem_write(addr + k, r);
			exp_q.push_back(r[31:24]);
			exp_q.push_back(r[23:16]);
			exp_q.push_back(r[15:8]);
			exp_q.push_back(r[7:0]);
		end
	endtask

	task automatic expect_tx_stream();
		logic [7:0] exp_b;
		logic [7:0] got_b;
		int idx;
		int waited;
		idx = 0;
		while (exp_q.size() > 0) begin
			waited = 0;
			while (tx_got.size() == 0) begin
				@(posedge sys_clk);
				waited++;
				if (waited > BYTE_TIMEOUT)
					report_failure($sformatf("Transmit byte %0d never arrived", idx));
			end
			exp_b = exp_q.pop_front();
			got_b = tx_got.pop_front();
			check_byte($sformatf("o_tx_data[%0d]", idx), exp_b, got_b);
			idx++;
		end
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(posedge sys_clk);
			if (busy)
				report_failure("A transfer started that should have been ignored");
		end
		if (tx_got.size() != 0)
			report_failure("Extra transmit bytes appeared after the transfer");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_write_then_read();
		logic [31:0] got;
		send_frame(uart_dma_pkg::CMD_ADDR, 32'd100);
		send_frame(uart_dma_pkg::CMD_LEN, 32'd16);
		start_transfer(uart_dma_pkg::OP_WRITE);
		send_payload(64);
		wait_busy(1'b0, "fall after the write");
		for (int k = 0; k < 16; k++) begin
			u_mem.mem_read(32'd100 + k, got);
			check_word($sformatf("mem[%0d]", 100 + k),
				{pay_q[4*k], pay_q[4*k+1], pay_q[4*k+2], pay_q[4*k+3]}, got);
		end
	endtask

	task automatic test_partial_burst();
		send_frame(uart_dma_pkg::CMD_ADDR, 32'd200);
		send_frame(uart_dma_pkg::CMD_LEN, 32'd37);
		start_transfer(uart_dma_pkg::OP_WRITE);
		send_payload(148);
		wait_busy(1'b0, "fall after the write");
		exp_q = pay_q;
		start_transfer(uart_dma_pkg::OP_READ);
		expect_tx_stream();
		wait_busy(1'b0, "fall after the read");
		check_idle(100);
	endtask

	task automatic test_malformed_frames();
		send_frame(uart_dma_pkg::CMD_ADDR, 32'd300);
		send_frame(uart_dma_pkg::CMD_LEN, 32'd4);
		// Length frame closed by a wrong byte
		send_byte(OPEN_BRACE);
		send_byte(uart_dma_pkg::CMD_LEN);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte(8'h63);
		send_byte(8'h7c);
		// Unknown id carrying a start bit
		send_frame(8'h07, 32'h0000_0001);
		check_idle(20);
		preload_words(32'd300, 4);
		start_transfer(uart_dma_pkg::OP_READ);
		expect_tx_stream();
		wait_busy(1'b0, "fall after the read");
		check_idle(100);
	endtask

	task automatic test_tx_backpressure();
		send_frame(uart_dma_pkg::CMD_ADDR, 32'd400);
		send_frame(uart_dma_pkg::CMD_LEN, 32'd40);
		preload_words(32'd400, 40);
		start_transfer(uart_dma_pkg::OP_READ);
		// Busy pattern only once no stimulus draws random numbers
		busy_rand = 1'b1;
		expect_tx_stream();
		busy_rand = 1'b0;
		wait_busy(1'b0, "fall after the read");
		check_idle(100);
	endtask

	task automatic test_busy_window();
		send_frame(uart_dma_pkg::CMD_ADDR, 32'd500);
		send_frame(uart_dma_pkg::CMD_LEN, 32'd40);
		preload_words(32'd500, 40);
		if (busy)
			report_failure("o_busy was high before the start frame");
		// Stalled transmitter keeps the read open
		busy_hold = 1'b1;
		start_transfer(uart_dma_pkg::OP_READ);
		send_frame(uart_dma_pkg::CMD_START, 32'h0000_0003);
		if (!busy)
			report_failure("Read ended before the second start frame completed");
		busy_hold = 1'b0;
		expect_tx_stream();
		wait_busy(1'b0, "fall after the read");
		check_idle(300);
	endtask

	initial begin
		rng_state   = 32'hf5d57fad;
		axi_reset_n = 1'b0;
		rx_valid    = 1'b0;
		rx_data     = 8'h00;
		tx_busy     = 1'b0;
		busy_rand   = 1'b0;
		busy_hold   = 1'b0;
		repeat (4) @(posedge sys_clk);
		axi_reset_n <= 1'b1;
		@(posedge sys_clk);
		if (busy || tx_start || wr_m.req || rd_m.req || wr_m.data_ready || rd_m.data_ready)
			report_failure("DUT outputs were not low after reset");
		test_write_then_read();
		test_partial_burst();
		test_malformed_frames();
		test_tx_backpressure();
		test_busy_window();
		if (busy || (tx_got.size() != 0))
			report_failure("DUT was not idle at the end of the run");
		else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

//--- verif/tb_dma_mem_model.sv
`timescale 1ns/1ps

module tb_dma_mem_model #(
	parameter int BURST_LEN = 16
) (
	input  logic                    i_sys_clk,
	input  logic                    i_axi_reset_n,
	input  uart_dma_pkg::dma_wr_m_t i_wr,
	output uart_dma_pkg::dma_wr_s_t o_wr,
	input  uart_dma_pkg::dma_rd_m_t i_rd,
	output uart_dma_pkg::dma_rd_s_t o_rd
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_WAIT  = 2'd1;
	localparam logic [1:0] ST_BURST = 2'd2;

	logic [31:0] mem [4096];
	logic [1:0]  wr_st;
	logic [1:0]  rd_st;
	logic [31:0] wr_addr;
	logic [31:0] wr_rem;
	logic [31:0] wr_cnt;
	logic [31:0] rd_addr;
	logic [31:0] rd_rem;
	logic [31:0] rd_cnt;

	function automatic logic [31:0] burst_words(input logic [31:0] rem);
		return (rem < 32'(BURST_LEN)) ? rem : 32'(BURST_LEN);
	endfunction

	task automatic mem_write(input logic [31:0] addr, input logic [31:0] data);
		mem[addr[11:0]] = data;
	endtask

	task automatic mem_read(input logic [31:0] addr, output logic [31:0] data);
		data = mem[addr[11:0]];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_sys_clk) begin
		if (!i_axi_reset_n) begin
			o_wr  <= '0;
			wr_st <= ST_IDLE;
		end else begin
			o_wr.ack      <= 1'b0;
			o_wr.done     <= 1'b0;
			o_wr.data_req <= 1'b0;
			// Head word is taken in the same cycle as the pull
			if (o_wr.data_req) begin
				mem[wr_addr[11:0]] <= i_wr.data;
				wr_addr            <= wr_addr + 32'd1;
				wr_rem             <= wr_rem - 32'd1;
			end
			case (wr_st)
				ST_IDLE: begin
					if (i_wr.req && i_wr.data_ready) begin
						o_wr.ack <= 1'b1;
						wr_addr  <= i_wr.addr;
						wr_rem   <= i_wr.len;
						wr_st    <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (wr_rem == 32'd0) begin
						o_wr.done <= 1'b1;
						wr_st     <= ST_IDLE;
					end else if (i_wr.data_ready) begin
						wr_cnt <= burst_words(wr_rem);
						wr_st  <= ST_BURST;
					end
				end
				ST_BURST: begin
					if (wr_cnt != 32'd0) begin
						o_wr.data_req <= 1'b1;
						wr_cnt        <= wr_cnt - 32'd1;
					end else begin
						wr_st <= ST_WAIT;
					end
				end
				default: wr_st <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_sys_clk) begin
		if (!i_axi_reset_n) begin
			o_rd  <= '0;
			rd_st <= ST_IDLE;
		end else begin
			o_rd.ack        <= 1'b0;
			o_rd.done       <= 1'b0;
			o_rd.data_valid <= 1'b0;
			case (rd_st)
				ST_IDLE: begin
					if (i_rd.req) begin
						o_rd.ack <= 1'b1;
						rd_addr  <= i_rd.addr;
						rd_rem   <= i_rd.len;
						rd_st    <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					// New burst only with room for all of it
					if (rd_rem == 32'd0) begin
						o_rd.done <= 1'b1;
						rd_st     <= ST_IDLE;
					end else if (i_rd.data_ready) begin
						rd_cnt <= burst_words(rd_rem);
						rd_st  <= ST_BURST;
					end
				end
				ST_BURST: begin
					if (rd_cnt != 32'd0) begin
						o_rd.data_valid <= 1'b1;
						o_rd.data       <= mem[rd_addr[11:0]];
						rd_addr         <= rd_addr + 32'd1;
						rd_rem          <= rd_rem - 32'd1;
						rd_cnt          <= rd_cnt - 32'd1;
					end else begin
						rd_st <= ST_WAIT;
					end
				end
				default: rd_st <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/uart_dma_top.sv
`timescale 1ns/1ps

module uart_dma_top #(
	parameter int BURST_LEN = 16
) (
	input  logic                    i_sys_clk,
	input  logic                    i_axi_reset_n,
	input  logic                    i_rx_valid,
	input  logic [7:0]              i_rx_data,
	input  logic                    i_tx_busy,
	output logic                    o_tx_start,
	output logic [7:0]              o_tx_data,
	output logic                    o_busy,
	output uart_dma_pkg::dma_wr_m_t o_wr,
	input  uart_dma_pkg::dma_wr_s_t i_wr,
	output uart_dma_pkg::dma_rd_m_t o_rd,
	input  uart_dma_pkg::dma_rd_s_t i_rd
);

	localparam int CW = $clog2(2 * BURST_LEN) + 1;

	uart_dma_pkg::dma_cmd_t  cmd;
	uart_dma_pkg::dma_wr_m_t ctrl_wr;
	logic                    cmd_valid;
	logic                    wr_accept;
	logic                    rd_space_ok;
	logic [CW-1:0]           wr_count;
	logic [31:0]             wr_data;

	// Write payload comes straight from the FIFO head
	always_comb begin
		o_wr      = ctrl_wr;
		o_wr.data = wr_data;
	end

	uart_cmd_parser u_parser (
		.i_sys_clk     (i_sys_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_rx_valid    (i_rx_valid),
		.i_rx_data     (i_rx_data),
		.i_wr_accept   (wr_accept),
		.o_cmd         (cmd),
		.o_cmd_valid   (cmd_valid)
	);

	uart_wr_buffer #(.BURST_LEN(BURST_LEN)) u_wr_buf (
		.i_sys_clk     (i_sys_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_rx_valid    (i_rx_valid),
		.i_rx_data     (i_rx_data),
		.i_wr_accept   (wr_accept),
		.i_data_req    (i_wr.data_req),
		.o_data        (wr_data),
		.o_count       (wr_count)
	);

	uart_rd_serializer #(.BURST_LEN(BURST_LEN)) u_rd_ser (
		.i_sys_clk     (i_sys_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_data        (i_rd.data),
		.i_data_valid  (i_rd.data_valid),
		.i_tx_busy     (i_tx_busy),
		.o_tx_start    (o_tx_start),
		.o_tx_data     (o_tx_data),
		.o_space_ok    (rd_space_ok)
	);

	dma_ctrl #(.BURST_LEN(BURST_LEN)) u_ctrl (
		.i_sys_clk     (i_sys_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_cmd         (cmd),
		.i_cmd_valid   (cmd_valid),
		.i_wr_count    (wr_count),
		.i_rd_space_ok (rd_space_ok),
		.o_wr_accept   (wr_accept),
		.o_busy        (o_busy),
		.o_wr          (ctrl_wr),
		.i_wr          (i_wr),
		.o_rd          (o_rd),
		.i_rd          (i_rd)
	);

endmodule

//--- verilog/dma_ctrl.sv
`timescale 1ns/1ps

module dma_ctrl #(
	parameter int BURST_LEN = 16
) (
	input  logic                         i_sys_clk,
	input  logic                         i_axi_reset_n,
	input  uart_dma_pkg::dma_cmd_t       i_cmd,
	input  logic                         i_cmd_valid,
	input  logic [$clog2(2*BURST_LEN):0] i_wr_count,
	input  logic                         i_rd_space_ok,
	output logic                         o_wr_accept,
	output logic                         o_busy,
	output uart_dma_pkg::dma_wr_m_t      o_wr,
	input  uart_dma_pkg::dma_wr_s_t      i_wr,
	output uart_dma_pkg::dma_rd_m_t      o_rd,
	input  uart_dma_pkg::dma_rd_s_t      i_rd
);

	uart_dma_pkg::ctrl_state_e state;
	uart_dma_pkg::dma_cmd_t    cmd_q;
	logic [31:0]               remain_q;
	logic                      wr_phase;
	logic                      rd_phase;
	logic [31:0]               wr_avail;
	logic [31:0]               wr_left;
	logic [31:0]               wr_need;
	logic [31:0]               wr_owed;

	assign wr_phase = state inside {uart_dma_pkg::CS_WR_REQ, uart_dma_pkg::CS_WR_BURST,
		uart_dma_pkg::CS_WR_DONE};
	assign rd_phase = state inside {uart_dma_pkg::CS_RD_REQ, uart_dma_pkg::CS_RD_BURST,
		uart_dma_pkg::CS_RD_DONE};
	assign o_busy   = (state != uart_dma_pkg::CS_IDLE);

	////////////////////////////////////////////////////////////////////////////
	// Burst readiness
	////////////////////////////////////////////////////////////////////////////

	// A pull in flight this cycle is already spoken for
	assign wr_avail = 32'(i_wr_count) - 32'(i_wr.data_req);
	assign wr_left  = remain_q - 32'(i_wr.data_req);
	assign wr_need  = (wr_left < 32'(BURST_LEN)) ? wr_left : 32'(BURST_LEN);

	// Words the UART has yet to deliver
	assign wr_owed     = remain_q - 32'(i_wr_count);
	assign o_wr_accept = wr_phase && (wr_owed != 32'd0);

	always_comb begin
		o_wr            = '0;
		o_wr.req        = (state == uart_dma_pkg::CS_WR_REQ);
		o_wr.addr       = cmd_q.addr;
		o_wr.len        = cmd_q.len;
		o_wr.data_ready = wr_phase && (wr_avail >= wr_need);
	end

	always_comb begin
		o_rd.req        = (state == uart_dma_pkg::CS_RD_REQ);
		o_rd.addr       = cmd_q.addr;
		o_rd.len        = cmd_q.len;
		o_rd.data_ready = rd_phase && i_rd_space_ok;
	end

	////////////////////////////////////////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk) begin
		if (!i_axi_reset_n) begin
			state    <= uart_dma_pkg::CS_IDLE;
			remain_q <= 32'd0;
		end else begin
			if ((wr_phase && i_wr.data_req) || (rd_phase && i_rd.data_valid))
				remain_q <= remain_q - 32'd1;
			case (state)
				uart_dma_pkg::CS_IDLE: begin
					// Commands while busy are dropped
					if (i_cmd_valid) begin
						remain_q <= i_cmd.len;
						state    <= (i_cmd.op == uart_dma_pkg::OP_READ) ?
							uart_dma_pkg::CS_RD_REQ : uart_dma_pkg::CS_WR_REQ;
					end
				end
				uart_dma_pkg::CS_WR_REQ: begin
					if (i_wr.ack)
						state <= uart_dma_pkg::CS_WR_BURST;
				end
				uart_dma_pkg::CS_WR_BURST: begin
					if (i_wr.done)
						state <= uart_dma_pkg::CS_IDLE;
					else if (remain_q == 32'd0)
						state <= uart_dma_pkg::CS_WR_DONE;
				end
				uart_dma_pkg::CS_WR_DONE: begin
					if (i_wr.done)
						state <= uart_dma_pkg::CS_IDLE;
				end
				uart_dma_pkg::CS_RD_REQ: begin
					if (i_rd.ack)
						state <= uart_dma_pkg::CS_RD_BURST;
				end
				uart_dma_pkg::CS_RD_BURST: begin
					if (i_rd.done)
						state <= uart_dma_pkg::CS_IDLE;
					else if (remain_q == 32'd0)
						state <= uart_dma_pkg::CS_RD_DONE;
				end
				uart_dma_pkg::CS_RD_DONE: begin
					if (i_rd.done)
						state <= uart_dma_pkg::CS_IDLE;
				end
				default: state <= uart_dma_pkg::CS_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if ((state == uart_dma_pkg::CS_IDLE) && i_cmd_valid)
			cmd_q <= i_cmd;
	end

	// Request and its address hold until the slave answers
	assert property (@(posedge i_sys_clk) disable iff (!i_axi_reset_n)
		(o_wr.req && !i_wr.ack) |=> (o_wr.req && $stable(o_wr.addr) && $stable(o_wr.len)));
	assert property (@(posedge i_sys_clk) disable iff (!i_axi_reset_n)
		(o_rd.req && !i_rd.ack) |=> (o_rd.req && $stable(o_rd.addr) && $stable(o_rd.len)));

endmodule

//--- verilog/uart_rd_serializer.sv
`timescale 1ns/1ps

module uart_rd_serializer #(
	parameter int BURST_LEN = 16
) (
	input  logic        i_sys_clk,
	input  logic        i_axi_reset_n,
	input  logic [31:0] i_data,
	input  logic        i_data_valid,
	input  logic        i_tx_busy,
	output logic        o_tx_start,
	output logic [7:0]  o_tx_data,
	output logic        o_space_ok
);

	localparam int DEPTH = 2 * BURST_LEN;
	localparam int AW    = $clog2(DEPTH);

	logic [31:0]   mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic [31:0]   word_q;
	logic [1:0]    byte_idx;
	logic          have_word;
	logic          gap_q;
	logic          load;

	// Take the next word once the previous one is fully sent
	assign load = !have_word && (count != '0);

	// gap_q leaves the transmitter one cycle to raise busy
	assign o_tx_start = have_word && !gap_q && !i_tx_busy;
	assign o_tx_data  = word_q[31:24];

	// A word arriving this cycle already takes its slot
	assign o_space_ok = (32'(count) + 32'(i_data_valid)) <= 32'(DEPTH - BURST_LEN);

	always_ff @(posedge i_sys_clk) begin
		if (!i_axi_reset_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			byte_idx  <= 2'd0;
			have_word <= 1'b0;
			gap_q     <= 1'b0;
		end else begin
			gap_q <= o_tx_start;
			if (i_data_valid)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (load) begin
				rd_ptr    <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				have_word <= 1'b1;
				byte_idx  <= 2'd0;
			end else if (o_tx_start) begin
				byte_idx <= byte_idx + 2'd1;
				if (byte_idx == 2'd3)
					have_word <= 1'b0;
			end
			case ({i_data_valid, load})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Word storage and output shifter
	always_ff @(posedge i_sys_clk) begin
		if (i_data_valid)
			mem[wr_ptr] <= i_data;
		if (load)
			word_q <= mem[rd_ptr];
		else if (o_tx_start)
			word_q <= {word_q[23:0], 8'h00};
	end

	// Slave must hold off new bursts while space is short
	assert property (@(posedge i_sys_clk) disable iff (!i_axi_reset_n)
		i_data_valid |-> (count < DEPTH));

endmodule

//--- verilog/uart_wr_buffer.sv
`timescale 1ns/1ps

module uart_wr_buffer #(
	parameter int BURST_LEN = 16
) (
	input  logic                          i_sys_clk,
	input  logic                          i_axi_reset_n,
	input  logic                          i_rx_valid,
	input  logic [7:0]                    i_rx_data,
	input  logic                          i_wr_accept,
	input  logic                          i_data_req,
	output logic [31:0]                   o_data,
	output logic [$clog2(2*BURST_LEN):0]  o_count
);

	localparam int DEPTH = 2 * BURST_LEN;
	localparam int AW    = $clog2(DEPTH);

	logic [31:0]   mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [1:0]    byte_cnt;
	logic [23:0]   pack_q;
	logic          push;

	////////////////////////////////////////////////////////////////////////////
	// Byte packing, most significant byte first
	////////////////////////////////////////////////////////////////////////////

	assign push = i_rx_valid && i_wr_accept && (byte_cnt == 2'd3);

	always_ff @(posedge i_sys_clk) begin
		if (!i_axi_reset_n)
			byte_cnt <= 2'd0;
		else if (!i_wr_accept)
			byte_cnt <= 2'd0;
		else if (i_rx_valid)
			byte_cnt <= byte_cnt + 2'd1;
	end

	always_ff @(posedge i_sys_clk) begin
		if (i_rx_valid && i_wr_accept)
			pack_q <= {pack_q[15:0], i_rx_data};
		if (push)
			mem[wr_ptr] <= {pack_q, i_rx_data};
	end

	////////////////////////////////////////////////////////////////////////////
	// Word FIFO towards the DMA slave
	////////////////////////////////////////////////////////////////////////////

	// Head word is visible before the slave pulls it
	assign o_data = mem[rd_ptr];

	always_ff @(posedge i_sys_clk) begin
		if (!i_axi_reset_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (i_data_req)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, i_data_req})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count;
			endcase
		end
	end

	// More bytes than len words would overrun the queue
	assert property (@(posedge i_sys_clk) disable iff (!i_axi_reset_n)
		push |-> (o_count < DEPTH));

	// Slave pulls only what data_ready promised
	assert property (@(posedge i_sys_clk) disable iff (!i_axi_reset_n)
		i_data_req |-> (o_count != '0));

endmodule

//--- verilog/uart_cmd_parser.sv
`timescale 1ns/1ps

module uart_cmd_parser (
	input  logic                   i_sys_clk,
	input  logic                   i_axi_reset_n,
	input  logic                   i_rx_valid,
	input  logic [7:0]             i_rx_data,
	input  logic                   i_wr_accept,
	output uart_dma_pkg::dma_cmd_t o_cmd,
	output logic                   o_cmd_valid
);

	// Braces around each frame
	localparam logic [7:0] FRAME_OPEN  = 8'h7b;
	localparam logic [7:0] FRAME_CLOSE = 8'h7d;

	uart_dma_pkg::parser_state_e state;
	logic [7:0]                  id_q;
	logic [31:0]                 arg_q;
	logic [1:0]                  arg_cnt;
	logic [31:0]                 addr_q;
	logic [31:0]                 len_q;
	logic                        rx_take;
	logic                        frame_end;
	logic                        start_hit;

	// Write payload belongs to the write buffer
	assign rx_take   = i_rx_valid && !i_wr_accept;
	assign frame_end = rx_take && (state == uart_dma_pkg::PS_CLOSE) &&
		(i_rx_data == FRAME_CLOSE);
	assign start_hit = frame_end && (id_q == uart_dma_pkg::CMD_START) && arg_q[0];

	always_ff @(posedge i_sys_clk) begin
		if (!i_axi_reset_n) begin
			state       <= uart_dma_pkg::PS_IDLE;
			arg_cnt     <= 2'd0;
			addr_q      <= 32'd0;
			len_q       <= 32'd0;
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= start_hit;
			if (rx_take) begin
				case (state)
					uart_dma_pkg::PS_IDLE: begin
						if (i_rx_data == FRAME_OPEN)
							state <= uart_dma_pkg::PS_ID;
					end
					uart_dma_pkg::PS_ID: begin
						arg_cnt <= 2'd0;
						state   <= uart_dma_pkg::PS_ARG;
					end
					uart_dma_pkg::PS_ARG: begin
						arg_cnt <= arg_cnt + 2'd1;
						if (arg_cnt == 2'd3)
							state <= uart_dma_pkg::PS_CLOSE;
					end
					uart_dma_pkg::PS_CLOSE: begin
						// Bad closing byte or unknown id drops the frame
						state <= uart_dma_pkg::PS_IDLE;
						if (frame_end) begin
							case (id_q)
								uart_dma_pkg::CMD_ADDR: addr_q <= arg_q;
								uart_dma_pkg::CMD_LEN:  len_q  <= arg_q;
								default: ;
							endcase
						end
					end
					default: state <= uart_dma_pkg::PS_IDLE;
				endcase
			end
		end
	end

	// Id and argument shift register
	always_ff @(posedge i_sys_clk) begin
		if (rx_take && (state == uart_dma_pkg::PS_ID))
			id_q <= i_rx_data;
		if (rx_take && (state == uart_dma_pkg::PS_ARG))
			arg_q <= {arg_q[23:0], i_rx_data};
		if (start_hit) begin
			o_cmd.op   <= arg_q[1] ? uart_dma_pkg::OP_READ : uart_dma_pkg::OP_WRITE;
			o_cmd.addr <= addr_q;
			o_cmd.len  <= len_q;
		end
	end

	// No start frame can complete while write payload is flowing
	assert property (@(posedge i_sys_clk) disable iff (!i_axi_reset_n)
		o_cmd_valid |-> !i_wr_accept);

endmodule

//--- verilog/uart_dma_pkg.sv
package uart_dma_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Frame and transfer encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [7:0] {
		CMD_ADDR  = 8'd3,
		CMD_LEN   = 8'd4,
		CMD_START = 8'd5
	} cmd_id_e;

	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} dma_op_e;

	typedef enum logic [1:0] {
		PS_IDLE,
		PS_ID,
		PS_ARG,
		PS_CLOSE
	} parser_state_e;

	typedef enum logic [2:0] {
		CS_IDLE,
		CS_WR_REQ,
		CS_WR_BURST,
		CS_WR_DONE,
		CS_RD_REQ,
		CS_RD_BURST,
		CS_RD_DONE
	} ctrl_state_e;

	// One transfer handed from parser to controller
	typedef struct packed {
		dma_op_e     op;
		logic [31:0] addr;
		logic [31:0] len;
	} dma_cmd_t;

	////////////////////////////////////////////////////////////////////////////
	// DMA slave port
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        req;
		logic [31:0] addr;
		logic [31:0] len;
		logic [31:0] data;
		logic        data_ready;
	} dma_wr_m_t;

	typedef struct packed {
		logic ack;
		logic data_req;
		logic done;
	} dma_wr_s_t;

	typedef struct packed {
		logic        req;
		logic [31:0] addr;
		logic [31:0] len;
		logic        data_ready;
	} dma_rd_m_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] data;
		logic        data_valid;
		logic        done;
	} dma_rd_s_t;

endpackage
